//--- csr_macros.svh
////////////////////////////////////////////////////////////////////////////
// widths, field positions and reset values of the machine-mode CSR block
////////////////////////////////////////////////////////////////////////////

`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN             32
`define CSR_CNT_W            64
`define CSR_CAUSE_W          6
`define CSR_NUM_FAST_IRQ     15

// mstatus fields kept by this core
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MSTATUS_MPP_LO   11
`define CSR_MSTATUS_MPP_HI   12

// mie / mip bit positions
`define CSR_MSIX_BIT         3
`define CSR_MTIX_BIT         7
`define CSR_MEIX_BIT         11
`define CSR_MFIX_LO          16

`define CSR_MTVEC_RESET      32'h0000_0001
`define CSR_MISA_VALUE       32'h4010_1104

`endif

//--- csr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types of the CSR block
// data words, address and op encodings, interrupt and write bundles
////////////////////////////////////////////////////////////////////////////

`include "csr_macros.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0]    xlen_t;
  typedef logic [`CSR_CNT_W-1:0]   counter_t;
  typedef logic [`CSR_CAUSE_W-1:0] cause_t;

  // implemented CSR addresses only
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHARTID       = 12'hF14
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef struct packed {
    logic                         irq_software;
    logic                         irq_timer;
    logic                         irq_external;
    logic [`CSR_NUM_FAST_IRQ-1:0] irq_fast;
  } irqs_t;

  // one strobe per writable register, at most one set per cycle
  typedef struct packed {
    logic  mstatus;
    logic  mie;
    logic  mtvec;
    logic  mcountinhibit;
    logic  mscratch;
    logic  mepc;
    logic  mcause;
    logic  mcycle;
    logic  mcycleh;
    logic  minstret;
    logic  minstreth;
    xlen_t wdata;
  } csr_wr_t;

  typedef struct packed {
    logic   save_cause;
    logic   restore_mret;
    xlen_t  exc_pc;
    cause_t cause;
  } trap_req_t;

  typedef struct packed {
    logic      mstatus_mie;
    logic      mstatus_mpie;
    priv_lvl_e mstatus_mpp;
    irqs_t     mie;
    irqs_t     mip;
    xlen_t     mscratch;
    xlen_t     mepc;
    cause_t    mcause;
    xlen_t     mtvec;
    counter_t  mcycle;
    counter_t  minstret;
    xlen_t     mcountinhibit;
  } csr_view_t;

endpackage

//--- csr_access.sv
////////////////////////////////////////////////////////////////////////////
// CSR access decode, privilege and read-only checks,
// write data for the op and the read multiplexer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_access (
  input  logic                csr_access_i,
  input  csr_pkg::csr_addr_e  csr_addr_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  input  logic                csr_op_en_i,
  input  csr_pkg::xlen_t      csr_wdata_i,
  input  csr_pkg::xlen_t      hart_id_i,
  input  csr_pkg::priv_lvl_e  priv_lvl_i,
  input  csr_pkg::csr_view_t  view_i,
  output csr_pkg::xlen_t      csr_rdata_o,
  output logic                illegal_csr_insn_o,
  output csr_pkg::csr_wr_t    wr_o
);

  import csr_pkg::*;

  logic  unknown_csr;
  logic  illegal_priv;
  logic  illegal_write;
  logic  wreq;
  logic  we;
  xlen_t wdata_int;

  // spread an interrupt bundle over its mie/mip bit positions
  function automatic xlen_t irq_word(irqs_t irqs);
    xlen_t word;
    word                                                     = '0;
    word[`CSR_MSIX_BIT]                                      = irqs.irq_software;
    word[`CSR_MTIX_BIT]                                      = irqs.irq_timer;
    word[`CSR_MEIX_BIT]                                      = irqs.irq_external;
    word[`CSR_MFIX_LO+`CSR_NUM_FAST_IRQ-1:`CSR_MFIX_LO]      = irqs.irq_fast;
    return word;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // read multiplexer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    unknown_csr = 1'b0;
    case (csr_addr_i)
      CSR_MHARTID:  csr_rdata_o = hart_id_i;
      CSR_MISA:     csr_rdata_o = `CSR_MISA_VALUE;
      CSR_MSTATUS: begin
        csr_rdata_o[`CSR_MSTATUS_MIE_BIT]                      = view_i.mstatus_mie;
        csr_rdata_o[`CSR_MSTATUS_MPIE_BIT]                     = view_i.mstatus_mpie;
        csr_rdata_o[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO]   = view_i.mstatus_mpp;
      end
      CSR_MIE:      csr_rdata_o = irq_word(view_i.mie);
      CSR_MIP:      csr_rdata_o = irq_word(view_i.mip);
      CSR_MTVEC:    csr_rdata_o = view_i.mtvec;
      CSR_MSCRATCH: csr_rdata_o = view_i.mscratch;
      CSR_MEPC:     csr_rdata_o = view_i.mepc;
      // interrupt flag on top, code in the low bits
      CSR_MCAUSE: begin
        csr_rdata_o = {view_i.mcause[`CSR_CAUSE_W-1], 26'b0, view_i.mcause[4:0]};
      end
      CSR_MCOUNTINHIBIT: csr_rdata_o = view_i.mcountinhibit;
      CSR_MCYCLE:        csr_rdata_o = view_i.mcycle[`CSR_XLEN-1:0];
      CSR_MCYCLEH:       csr_rdata_o = view_i.mcycle[`CSR_CNT_W-1:`CSR_XLEN];
      CSR_MINSTRET:      csr_rdata_o = view_i.minstret[`CSR_XLEN-1:0];
      CSR_MINSTRETH:     csr_rdata_o = view_i.minstret[`CSR_CNT_W-1:`CSR_XLEN];
      default:           unknown_csr = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks and write strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    wreq = csr_access_i & csr_op_en_i;
    case (csr_op_i)
      CSR_OP_WRITE: wdata_int = csr_wdata_i;
      CSR_OP_SET:   wdata_int = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: wdata_int = ~csr_wdata_i & csr_rdata_o;
      default: begin
        wdata_int = csr_wdata_i;
        wreq      = 1'b0;
      end
    endcase
  end

  // bits 9:8 give the lowest privilege, 11:10 == 11 marks read-only
  assign illegal_priv       = (csr_addr_i[9:8] > priv_lvl_i);
  assign illegal_write      = (csr_addr_i[11:10] == 2'b11) & wreq;
  assign illegal_csr_insn_o = csr_access_i & (unknown_csr | illegal_priv | illegal_write);
  assign we                 = wreq & ~illegal_csr_insn_o;

  always_comb begin
    wr_o       = '0;
    wr_o.wdata = wdata_int;
    if (we) begin
      case (csr_addr_i)
        CSR_MSTATUS:       wr_o.mstatus       = 1'b1;
        CSR_MIE:           wr_o.mie           = 1'b1;
        CSR_MTVEC:         wr_o.mtvec         = 1'b1;
        CSR_MCOUNTINHIBIT: wr_o.mcountinhibit = 1'b1;
        CSR_MSCRATCH:      wr_o.mscratch      = 1'b1;
        CSR_MEPC:          wr_o.mepc          = 1'b1;
        CSR_MCAUSE:        wr_o.mcause        = 1'b1;
        CSR_MCYCLE:        wr_o.mcycle        = 1'b1;
        CSR_MCYCLEH:       wr_o.mcycleh       = 1'b1;
        CSR_MINSTRET:      wr_o.minstret      = 1'b1;
        CSR_MINSTRETH:     wr_o.minstreth     = 1'b1;
        // misa and mip ignore writes
        default: ;
      endcase
    end
  end

endmodule

//--- csr_priv_fsm.sv
////////////////////////////////////////////////////////////////////////////
// privilege level FSM with the mstatus MIE/MPIE/MPP stack
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_priv_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  csr_pkg::csr_wr_t    wr_i,
  input  csr_pkg::trap_req_t  trap_i,
  output csr_pkg::priv_lvl_e  priv_lvl_o,
  output logic                mstatus_mie_o,
  output logic                mstatus_mpie_o,
  output csr_pkg::priv_lvl_e  mstatus_mpp_o
);

  import csr_pkg::*;

  priv_lvl_e priv_q, priv_d;
  priv_lvl_e mpp_q, mpp_d;
  logic      mie_q, mie_d;
  logic      mpie_q, mpie_d;

  always_comb begin
    priv_d = priv_q;
    mie_d  = mie_q;
    mpie_d = mpie_q;
    mpp_d  = mpp_q;

    if (wr_i.mstatus) begin
      mie_d  = wr_i.wdata[`CSR_MSTATUS_MIE_BIT];
      mpie_d = wr_i.wdata[`CSR_MSTATUS_MPIE_BIT];
      mpp_d  = priv_lvl_e'(wr_i.wdata[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO]);
      // only U and M exist, anything else maps to M
      if ((mpp_d != PRIV_LVL_U) && (mpp_d != PRIV_LVL_M)) begin
        mpp_d = PRIV_LVL_M;
      end
    end

    // trap and mret override a same-cycle mstatus write
    if (trap_i.save_cause) begin
      priv_d = PRIV_LVL_M;
      mpie_d = mie_q;
      mie_d  = 1'b0;
      mpp_d  = priv_q;
    end else if (trap_i.restore_mret) begin
      priv_d = mpp_q;
      mie_d  = mpie_q;
      mpie_d = 1'b1;
      mpp_d  = PRIV_LVL_U;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_q <= PRIV_LVL_M;
      mie_q  <= 1'b0;
      mpie_q <= 1'b1;
      mpp_q  <= PRIV_LVL_U;
    end else begin
      priv_q <= priv_d;
      mie_q  <= mie_d;
      mpie_q <= mpie_d;
      mpp_q  <= mpp_d;
    end
  end

  assign priv_lvl_o     = priv_q;
  assign mstatus_mie_o  = mie_q;
  assign mstatus_mpie_o = mpie_q;
  assign mstatus_mpp_o  = mpp_q;

endmodule

//--- csr_trap_regs.sv
////////////////////////////////////////////////////////////////////////////
// mie, mscratch, mepc, mcause and mtvec registers
// plus qualification of the interrupt lines with mie
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_trap_regs (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  csr_pkg::csr_wr_t                   wr_i,
  input  csr_pkg::trap_req_t                 trap_i,
  input  logic                               irq_software_i,
  input  logic                               irq_timer_i,
  input  logic                               irq_external_i,
  input  logic [`CSR_NUM_FAST_IRQ-1:0]       irq_fast_i,
  output csr_pkg::irqs_t                     mie_o,
  output csr_pkg::irqs_t                     mip_o,
  output csr_pkg::xlen_t                     mscratch_o,
  output csr_pkg::xlen_t                     mepc_o,
  output csr_pkg::xlen_t                     mtvec_o,
  output csr_pkg::cause_t                    mcause_o,
  output csr_pkg::irqs_t                     irqs_o,
  output logic                               irq_pending_o
);

  import csr_pkg::*;

  irqs_t  mie_q;
  xlen_t  mscratch_q;
  xlen_t  mepc_q;
  xlen_t  mtvec_q;
  cause_t mcause_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q      <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtvec_q    <= `CSR_MTVEC_RESET;
    end else begin
      if (wr_i.mie) begin
        mie_q <= '{irq_software: wr_i.wdata[`CSR_MSIX_BIT],
                   irq_timer:    wr_i.wdata[`CSR_MTIX_BIT],
                   irq_external: wr_i.wdata[`CSR_MEIX_BIT],
                   irq_fast:     wr_i.wdata[`CSR_MFIX_LO+`CSR_NUM_FAST_IRQ-1:`CSR_MFIX_LO]};
      end
      if (wr_i.mscratch) begin
        mscratch_q <= wr_i.wdata;
      end
      // 256-byte aligned base, mode fixed to vectored
      if (wr_i.mtvec) begin
        mtvec_q <= {wr_i.wdata[`CSR_XLEN-1:8], 6'b0, 2'b01};
      end
      // trap entry wins over software writes
      if (trap_i.save_cause) begin
        mepc_q   <= trap_i.exc_pc;
        mcause_q <= trap_i.cause;
      end else begin
        if (wr_i.mepc) begin
          mepc_q <= {wr_i.wdata[`CSR_XLEN-1:1], 1'b0};
        end
        if (wr_i.mcause) begin
          mcause_q <= {wr_i.wdata[`CSR_XLEN-1], wr_i.wdata[4:0]};
        end
      end
    end
  end

  // mip follows the raw lines
  assign mip_o.irq_software = irq_software_i;
  assign mip_o.irq_timer    = irq_timer_i;
  assign mip_o.irq_external = irq_external_i;
  assign mip_o.irq_fast     = irq_fast_i;

  assign irqs_o        = mip_o & mie_q;
  assign irq_pending_o = |irqs_o;

  assign mie_o      = mie_q;
  assign mscratch_o = mscratch_q;
  assign mepc_o     = mepc_q;
  assign mtvec_o    = mtvec_q;
  assign mcause_o   = mcause_q;

endmodule

//--- csr_perf_counters.sv
////////////////////////////////////////////////////////////////////////////
// mcycle and minstret counters with mcountinhibit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_perf_counters (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  csr_pkg::csr_wr_t  wr_i,
  input  logic              instr_ret_i,
  output csr_pkg::counter_t mcycle_o,
  output csr_pkg::counter_t minstret_o,
  output csr_pkg::xlen_t    mcountinhibit_o
);

  import csr_pkg::*;

  counter_t mcycle_q;
  counter_t minstret_q;
  logic     cy_inhibit_q;
  logic     ir_inhibit_q;
  logic     cy_incr;
  logic     ir_incr;

  // a half write replaces that half and drops the increment
  function automatic counter_t cnt_next(counter_t cnt, logic incr, logic wr_lo,
                                        logic wr_hi, xlen_t wdata);
    counter_t next;
    next = cnt;
    if (wr_lo) begin
      next[`CSR_XLEN-1:0] = wdata;
    end else if (wr_hi) begin
      next[`CSR_CNT_W-1:`CSR_XLEN] = wdata;
    end else if (incr) begin
      next = cnt + 1'b1;
    end
    return next;
  endfunction

  assign cy_incr = ~cy_inhibit_q;
  assign ir_incr = instr_ret_i & ~ir_inhibit_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q     <= '0;
      minstret_q   <= '0;
      cy_inhibit_q <= 1'b0;
      ir_inhibit_q <= 1'b0;
    end else begin
      mcycle_q   <= cnt_next(mcycle_q, cy_incr, wr_i.mcycle, wr_i.mcycleh, wr_i.wdata);
      minstret_q <= cnt_next(minstret_q, ir_incr, wr_i.minstret, wr_i.minstreth,
                             wr_i.wdata);
      if (wr_i.mcountinhibit) begin
        cy_inhibit_q <= wr_i.wdata[0];
        ir_inhibit_q <= wr_i.wdata[2];
      end
    end
  end

  // no time counter, bit 1 reads zero
  assign mcountinhibit_o = {{(`CSR_XLEN-3){1'b0}}, ir_inhibit_q, 1'b0, cy_inhibit_q};
  assign mcycle_o        = mcycle_q;
  assign minstret_o      = minstret_q;

endmodule

//--- csr_top.sv
////////////////////////////////////////////////////////////////////////////
// machine-mode CSR block top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          csr_access_i,
  input  csr_pkg::csr_addr_e            csr_addr_i,
  input  csr_pkg::csr_op_e              csr_op_i,
  input  logic                          csr_op_en_i,
  input  csr_pkg::xlen_t                csr_wdata_i,
  input  csr_pkg::xlen_t                hart_id_i,
  input  logic                          irq_software_i,
  input  logic                          irq_timer_i,
  input  logic                          irq_external_i,
  input  logic [`CSR_NUM_FAST_IRQ-1:0]  irq_fast_i,
  input  logic                          instr_ret_i,
  input  csr_pkg::trap_req_t            trap_i,
  output csr_pkg::xlen_t                csr_rdata_o,
  output logic                          illegal_csr_insn_o,
  output csr_pkg::priv_lvl_e            priv_mode_o,
  output csr_pkg::xlen_t                csr_mepc_o,
  output csr_pkg::xlen_t                csr_mtvec_o,
  output csr_pkg::irqs_t                irqs_o,
  output logic                          irq_pending_o
);

  import csr_pkg::*;

  csr_wr_t   wr;
  csr_view_t view;

  csr_access u_access (
    .csr_access_i       (csr_access_i),
    .csr_addr_i         (csr_addr_i),
    .csr_op_i           (csr_op_i),
    .csr_op_en_i        (csr_op_en_i),
    .csr_wdata_i        (csr_wdata_i),
    .hart_id_i          (hart_id_i),
    .priv_lvl_i         (priv_mode_o),
    .view_i             (view),
    .csr_rdata_o        (csr_rdata_o),
    .illegal_csr_insn_o (illegal_csr_insn_o),
    .wr_o               (wr)
  );

  csr_priv_fsm u_priv_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr_i           (wr),
    .trap_i         (trap_i),
    .priv_lvl_o     (priv_mode_o),
    .mstatus_mie_o  (view.mstatus_mie),
    .mstatus_mpie_o (view.mstatus_mpie),
    .mstatus_mpp_o  (view.mstatus_mpp)
  );

  csr_trap_regs u_trap_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr_i           (wr),
    .trap_i         (trap_i),
    .irq_software_i (irq_software_i),
    .irq_timer_i    (irq_timer_i),
    .irq_external_i (irq_external_i),
    .irq_fast_i     (irq_fast_i),
    .mie_o          (view.mie),
    .mip_o          (view.mip),
    .mscratch_o     (view.mscratch),
    .mepc_o         (view.mepc),
    .mtvec_o        (view.mtvec),
    .mcause_o       (view.mcause),
    .irqs_o         (irqs_o),
    .irq_pending_o  (irq_pending_o)
  );

  csr_perf_counters u_perf_counters (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wr_i            (wr),
    .instr_ret_i     (instr_ret_i),
    .mcycle_o        (view.mcycle),
    .minstret_o      (view.minstret),
    .mcountinhibit_o (view.mcountinhibit)
  );

  // trap vector and return address go straight to the core
  assign csr_mepc_o  = view.mepc;
  assign csr_mtvec_o = view.mtvec;

endmodule

//--- csr_scoreboard.sv
////////////////////////////////////////////////////////////////////////////
// testbench checker that compares CSR block outputs with golden values
// and counts checks and mismatches
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_scoreboard (
  input  logic                clk_i,
  input  logic                act_i,
  input  logic                obs_i,
  input  logic                irq_mode_i,
  input  logic [8*16-1:0]     name_i,
  input  csr_pkg::csr_addr_e  addr_i,
  input  csr_pkg::xlen_t      exp_rdata_i,
  input  logic                exp_ill_i,
  input  csr_pkg::priv_lvl_e  exp_priv_i,
  input  csr_pkg::xlen_t      rdata_i,
  input  logic                illegal_i,
  input  csr_pkg::priv_lvl_e  priv_i,
  input  csr_pkg::irqs_t      irqs_i,
  input  logic                pending_i,
  input  csr_pkg::xlen_t      mepc_i,
  input  csr_pkg::xlen_t      mtvec_i,
  output int                  err_cnt_o,
  output int                  chk_cnt_o
);

  import csr_pkg::*;

  int err_cnt = 0;
  int chk_cnt = 0;

  task automatic compare(input string what, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("MISMATCH %0s %0s: expected %h, actual %h", name_i, what, exp_v, act_v);
    end
  endtask

  // sample on the falling edge, long after the 2 ns input delay
  always @(negedge clk_i) begin
    if (act_i && !irq_mode_i) begin
      compare("illegal", {31'b0, exp_ill_i}, {31'b0, illegal_i});
    end
    if (obs_i) begin
      if (irq_mode_i) begin
        compare("irqs", exp_rdata_i, {14'b0, irqs_i});
        compare("pending", {31'b0, exp_ill_i}, {31'b0, pending_i});
      end else begin
        compare("rdata", exp_rdata_i, rdata_i);
        // the core-side copies of mepc and mtvec
        if (addr_i == CSR_MEPC) begin
          compare("mepc", exp_rdata_i, mepc_i);
        end
        if (addr_i == CSR_MTVEC) begin
          compare("mtvec", exp_rdata_i, mtvec_i);
        end
      end
      compare("priv", {30'b0, exp_priv_i}, {30'b0, priv_i});
    end
  end

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

endmodule

//--- csr_chk.sv
////////////////////////////////////////////////////////////////////////////
// assertions on privilege, trap entry, interrupt and access invariants
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_chk (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                csr_access_i,
  input  logic                illegal_i,
  input  csr_pkg::priv_lvl_e  priv_i,
  input  csr_pkg::trap_req_t  trap_i,
  input  csr_pkg::irqs_t      irqs_i,
  input  logic                irq_pending_i
);

  import csr_pkg::*;

  int fail_cnt = 0;

  // only U and M exist
  priv_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    priv_i inside {PRIV_LVL_U, PRIV_LVL_M})
    else begin
      fail_cnt++;
      $error("privilege level is neither U nor M");
    end

  trap_to_m: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trap_i.save_cause |=> priv_i == PRIV_LVL_M)
    else begin
      fail_cnt++;
      $error("privilege not M in the cycle after a trap");
    end

  pending_or: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_pending_i == (|irqs_i))
    else begin
      fail_cnt++;
      $error("irq_pending_o differs from the OR of irqs_o");
    end

  illegal_needs_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_i |-> csr_access_i)
    else begin
      fail_cnt++;
      $error("illegal raised without a CSR access");
    end

endmodule

bind csr_top csr_chk u_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .csr_access_i  (csr_access_i),
  .illegal_i     (illegal_csr_insn_o),
  .priv_i        (priv_mode_o),
  .trap_i        (trap_i),
  .irqs_i        (irqs_o),
  .irq_pending_i (irq_pending_o)
);

//--- tb_csr.sv
////////////////////////////////////////////////////////////////////////////
// testbench top for the CSR block
// clock, reset, golden vector reading, stimulus and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module tb_csr;

  import csr_pkg::*;

  typedef struct packed {
    logic [8*16-1:0] name;
    logic [8*8-1:0]  kind;
    logic [1:0]      op;
    logic [11:0]     addr;
    logic [31:0]     wdata;
    logic [31:0]     aux;
    logic [31:0]     rdata;
    logic            ill;
    logic [1:0]      priv;
  } vec_t;

  logic                         clk = 1'b0;
  logic                         rst_n;
  logic                         csr_access;
  csr_addr_e                    csr_addr;
  csr_op_e                      csr_op;
  logic                         csr_op_en;
  xlen_t                        csr_wdata;
  xlen_t                        hart_id;
  logic                         irq_software;
  logic                         irq_timer;
  logic                         irq_external;
  logic [`CSR_NUM_FAST_IRQ-1:0] irq_fast;
  logic                         instr_ret;
  trap_req_t                    trap;
  xlen_t                        csr_rdata;
  logic                         illegal;
  priv_lvl_e                    priv_mode;
  xlen_t                        csr_mepc;
  xlen_t                        csr_mtvec;
  irqs_t                        irqs;
  logic                         irq_pending;

  // expected values and strobes towards the scoreboard
  logic                         act;
  logic                         obs;
  logic                         irq_mode;
  logic [8*16-1:0]              cur_name;
  xlen_t                        exp_rdata;
  logic                         exp_ill;
  priv_lvl_e                    exp_priv;
  int                           sb_errs;
  int                           sb_checks;
  int                           other_errs = 0;
  logic                         loaded = 1'b0;
  vec_t                         vecs[$];

  always #20 clk = ~clk;

  csr_top dut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .csr_access_i       (csr_access),
    .csr_addr_i         (csr_addr),
    .csr_op_i           (csr_op),
    .csr_op_en_i        (csr_op_en),
    .csr_wdata_i        (csr_wdata),
    .hart_id_i          (hart_id),
    .irq_software_i     (irq_software),
    .irq_timer_i        (irq_timer),
    .irq_external_i     (irq_external),
    .irq_fast_i         (irq_fast),
    .instr_ret_i        (instr_ret),
    .trap_i             (trap),
    .csr_rdata_o        (csr_rdata),
    .illegal_csr_insn_o (illegal),
    .priv_mode_o        (priv_mode),
    .csr_mepc_o         (csr_mepc),
    .csr_mtvec_o        (csr_mtvec),
    .irqs_o             (irqs),
    .irq_pending_o      (irq_pending)
  );

  csr_scoreboard u_scoreboard (
    .clk_i       (clk),
    .act_i       (act),
    .obs_i       (obs),
    .irq_mode_i  (irq_mode),
    .name_i      (cur_name),
    .addr_i      (csr_addr),
    .exp_rdata_i (exp_rdata),
    .exp_ill_i   (exp_ill),
    .exp_priv_i  (exp_priv),
    .rdata_i     (csr_rdata),
    .illegal_i   (illegal),
    .priv_i      (priv_mode),
    .irqs_i      (irqs),
    .pending_i   (irq_pending),
    .mepc_i      (csr_mepc),
    .mtvec_i     (csr_mtvec),
    .err_cnt_o   (sb_errs),
    .chk_cnt_o   (sb_checks)
  );

  ////////////////////////////////////////////////////////////////////////////
  // golden file and stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_golden();
    int              fd;
    int              code;
    string           line;
    logic [8*16-1:0] nm;
    logic [8*8-1:0]  kd;
    logic [31:0]     op;
    logic [31:0]     addr;
    logic [31:0]     wd;
    logic [31:0]     aux;
    logic [31:0]     rd;
    logic [31:0]     il;
    logic [31:0]     pv;
    vec_t            v;
    fd = $fopen("csr_golden.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("cannot open the golden vector file csr_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        code = $sscanf(line, "%s %s %h %h %h %h %h %h %h", nm, kd, op, addr, wd, aux, rd,
                       il, pv);
        if (code != 9) begin
          other_errs++;
          $display("golden file line could not be parsed: %s", line);
        end else begin
          v.name  = nm;
          v.kind  = kd;
          v.op    = op[1:0];
          v.addr  = addr[11:0];
          v.wdata = wd;
          v.aux   = aux;
          v.rdata = rd;
          v.ill   = il[0];
          v.priv  = pv[1:0];
          vecs.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  // release bus and strobes while interrupt lines and address hold
  task automatic drive_idle();
    csr_access = 1'b0;
    csr_op     = CSR_OP_READ;
    csr_op_en  = 1'b0;
    csr_wdata  = '0;
    instr_ret  = 1'b0;
    trap       = '0;
  endtask

  // action phase followed by an observe phase on the same address
  task automatic run_vector(input vec_t v);
    int n;
    n = (v.kind == "ret") ? int'(v.aux) : 1;
    @(posedge clk);
    #2;
    drive_idle();
    cur_name  = v.name;
    exp_rdata = v.rdata;
    exp_ill   = v.ill;
    exp_priv  = priv_lvl_e'(v.priv);
    irq_mode  = (v.kind == "irq");
    csr_addr  = csr_addr_e'(v.addr);
    if (v.kind == "csr") begin
      csr_access = 1'b1;
      csr_op     = csr_op_e'(v.op);
      csr_op_en  = (v.op != 2'd0);
      csr_wdata  = v.wdata;
      {irq_software, irq_timer, irq_external, irq_fast} = v.aux[17:0];
    end else if (v.kind == "irq") begin
      {irq_software, irq_timer, irq_external, irq_fast} = v.aux[17:0];
    end else if (v.kind == "trap") begin
      trap.save_cause = 1'b1;
      trap.exc_pc     = v.wdata;
      trap.cause      = v.aux[`CSR_CAUSE_W-1:0];
    end else if (v.kind == "mret") begin
      trap.restore_mret = 1'b1;
    end else if (v.kind == "ret") begin
      instr_ret = 1'b1;
    end else begin
      other_errs++;
      $display("golden vector %0s has an unknown kind", v.name);
    end
    act = 1'b1;
    obs = 1'b0;
    repeat (n - 1) @(posedge clk);
    @(posedge clk);
    #2;
    drive_idle();
    act = 1'b0;
    obs = 1'b1;
  endtask

  initial begin
    int total;
    rst_n        = 1'b0;
    hart_id      = 32'h0000_0003;
    csr_addr     = CSR_MSTATUS;
    irq_software = 1'b0;
    irq_timer    = 1'b0;
    irq_external = 1'b0;
    irq_fast     = '0;
    drive_idle();
    act          = 1'b0;
    obs          = 1'b0;
    irq_mode     = 1'b0;
    cur_name     = '0;
    exp_rdata    = '0;
    exp_ill      = 1'b0;
    exp_priv     = PRIV_LVL_M;
    load_golden();
    if (vecs.size() == 0) begin
      other_errs++;
      $display("no test vectors found in the golden file");
    end
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    foreach (vecs[i]) begin
      run_vector(vecs[i]);
    end
    @(posedge clk);
    #2;
    obs = 1'b0;
    @(posedge clk);
    total = sb_errs + dut.u_chk.fail_cnt + other_errs;
    $display("checks %0d, mismatches %0d, assertion failures %0d, other errors %0d",
             sb_checks, sb_errs, dut.u_chk.fail_cnt, other_errs);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // at most 4 cycles per vector plus reset and a small margin
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = (longint'(vecs.size()) * 4 + 3 + 4) * 40;
    #(limit_ns);
    $display("timeout: the test vectors did not finish within %0d ns", limit_ns);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- csr_golden.txt
# name kind op addr wdata aux exp_rdata exp_illegal exp_priv (all but name and kind in hex)
# kinds csr, trap (wdata pc, aux cause), mret, irq (rdata is irqs_o, illegal is pending), ret
scr_write csr 1 340 a5a5f00f 0 a5a5f00f 0 3
scr_set csr 2 340 00000ff0 0 a5a5ffff 0 3
scr_clear csr 3 340 a0a00000 0 0505ffff 0 3
scr_read csr 0 340 ffffffff 0 0505ffff 0 3
mie_write csr 1 304 ffffffff 0 7fff0888 0 3
mie_clear csr 3 304 00000888 0 7fff0000 0 3
mie_set csr 2 304 00000008 0 7fff0008 0 3
mtvec_write csr 1 305 12345677 0 12345601 0 3
mepc_write csr 1 341 80000123 0 80000122 0 3
mstatus_reset csr 0 300 00000000 0 00000080 0 3
mstatus_mie csr 2 300 00000008 0 00000088 0 3
trap_entry trap 0 341 00000400 0b 00000400 0 3
trap_cause csr 0 342 00000000 0 0000000b 0 3
trap_status csr 0 300 00000000 0 00001880 0 3
mret_to_m mret 0 300 00000000 0 00000088 0 3
mret_to_u mret 0 300 00000000 0 00000088 0 0
u_read csr 0 340 00000000 0 0505ffff 1 0
u_write csr 1 340 deadbeef 0 0505ffff 1 0
trap_from_u trap 0 300 00000200 08 00000080 0 3
u_no_effect csr 0 340 00000000 0 0505ffff 0 3
hartid_read csr 0 f14 00000000 0 00000003 0 3
hartid_write csr 1 f14 12345678 0 00000003 1 3
unknown_addr csr 0 7c0 00000000 0 00000000 1 3
misa_read csr 0 301 00000000 0 40101104 0 3
mip_raw csr 0 344 00000000 20005 00050008 0 3
irq_qual irq 0 344 00000000 20005 00020005 1 3
irq_masked irq 0 344 00000000 18000 00000000 0 3
irq_fast_only irq 0 344 00000000 00100 00000100 1 3
inhibit_all csr 1 320 00000007 0 00000005 0 3
mcycle_write csr 1 b00 12345678 0 12345678 0 3
mcycleh_write csr 1 b80 00000042 0 00000042 0 3
mcycle_hold csr 0 b00 00000000 0 12345678 0 3
inhibit_cy csr 1 320 00000001 0 00000001 0 3
minstret_clr csr 1 b02 00000000 0 00000000 0 3
instret_3 ret 0 b02 00000000 3 00000003 0 3
minstreth_wr csr 1 b82 0000abcd 0 0000abcd 0 3
minstret_lo csr 0 b02 00000000 0 00000003 0 3

//--- sources.f
+incdir+.
csr_pkg.sv
csr_access.sv
csr_priv_fsm.sv
csr_trap_regs.sv
csr_perf_counters.sv
csr_top.sv
csr_scoreboard.sv
csr_chk.sv
tb_csr.sv
